/* render_pkg.sv */
// Scanline tile renderer shared constants
// Line, tile map, VRAM and palette sizes plus pipeline latencies

package render_pkg;

  // Line buffer geometry
  localparam int line_width     = 64;
  localparam int x_width        = 6;
  localparam int buf_addr_width = 7;

  // Layers
  localparam int num_layers  = 2;
  localparam int layer_width = 1;

  // World coordinates wrap at 512
  localparam int world_width     = 9;
  localparam int tile_bits       = 4;
  localparam int map_coord_width = 5;
  localparam int line_y_width    = 9;

  // Tile map entries with flip flags in the top bits
  localparam int map_addr_width = 11;
  localparam int map_data_width = 16;
  localparam int flip_x_bit     = 15;
  localparam int flip_y_bit     = 14;
  localparam int flip_xy_bit    = 13;

  // VRAM holds two pixels per word with the even pixel in the low byte
  localparam int vram_addr_width = 16;
  localparam int vram_data_width = 16;
  localparam int pixel_width     = 8;

  // Palette and output colors
  localparam int pal_index_width = 4;
  localparam int pal_addr_width  = 12;
  localparam int color_width     = 24;
  localparam int rgb_width       = 18;

  // Per-layer register width
  localparam int reg_width = 16;

  // Cycles from pixel issue
  localparam int fetch_latency  = 2;
  localparam int render_latency = 4;

endpackage

/* pipe_delay.sv */
// Fixed-length delay line
// Shifts any payload type through a chain of reset registers

module pipe_delay #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t d,
  output payload_t q
);

  payload_t stage [depth];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= d;
      for (int i = 1; i < depth; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[depth-1];

endmodule

/* render_control.sv */
// Line sequencer
// Issues one pixel per cycle for each enabled layer, then flags the finished line

module render_control (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                render_start,
  input  logic [render_pkg::num_layers-1:0]   layer_enable,
  output logic                                issue_valid,
  output logic [render_pkg::x_width-1:0]      issue_x,
  output logic [render_pkg::layer_width-1:0]  issue_layer,
  output logic                                line_done
);

  typedef enum logic [1:0] {st_idle, st_decide, st_draw} state_t;

  state_t                              state;
  logic [render_pkg::layer_width-1:0]  layer;
  logic [render_pkg::x_width-1:0]      x;
  logic [render_pkg::layer_width:0]    scan_from;
  logic [render_pkg::layer_width:0]    first;
  logic [render_pkg::layer_width-1:0]  next_layer;
  logic                                have_next;
  logic                                at_end;
  logic                                last_mark;

  // Search starts past the current layer while drawing
  assign first  = (state == st_draw) ? {1'b0, layer} + 1'b1 : scan_from;
  assign at_end = (x == render_pkg::line_width - 1);

  // Lowest enabled layer at or above first
  always_comb begin
    have_next  = 1'b0;
    next_layer = '0;
    for (int i = render_pkg::num_layers - 1; i >= 0; i--) begin
      if (layer_enable[i] && i >= int'(first)) begin
        have_next  = 1'b1;
        next_layer = i[render_pkg::layer_width-1:0];
      end
    end
  end

  // Decide issues pixel 0 of the layer it picks
  assign issue_valid = (state == st_draw) || (state == st_decide && have_next);
  assign issue_x     = x;
  assign issue_layer = (state == st_draw) ? layer : next_layer;

  // Marks the final issue, or the decide cycle of an empty line
  assign last_mark = ((state == st_draw) && at_end && !have_next) ||
                     ((state == st_decide) && !have_next);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      layer     <= '0;
      x         <= '0;
      scan_from <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (render_start) begin
            state     <= st_decide;
            scan_from <= '0;
            x         <= '0;
          end
        end
        st_decide: begin
          if (have_next) begin
            layer <= next_layer;
            x     <= x + 1'b1;
            state <= st_draw;
          end else begin
            state <= st_idle;
          end
        end
        st_draw: begin
          if (at_end) begin
            x         <= '0;
            scan_from <= first;
            state     <= have_next ? st_decide : st_idle;
          end else begin
            x <= x + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  pipe_delay #(
    .payload_t (logic),
    .depth     (render_pkg::render_latency)
  ) done_delay (
    .clk   (clk),
    .reset (reset),
    .d     (last_mark),
    .q     (line_done)
  );

endmodule

/* tile_fetch.sv */
// Tile fetch stage
// Scrolls the pixel into world space, reads the tile map, applies flips, forms VRAM address

module tile_fetch (
  input  logic                                                   clk,
  input  logic [render_pkg::x_width-1:0]                         issue_x,
  input  logic [render_pkg::layer_width-1:0]                     issue_layer,
  input  logic [render_pkg::line_y_width-1:0]                    line_y,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] scroll_x,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] scroll_y,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] data_offset,
  input  logic [render_pkg::num_layers-1:0]                      flip_enable,
  output logic [render_pkg::map_addr_width-1:0]                  map_addr,
  input  logic [render_pkg::map_data_width-1:0]                  map_data,
  output logic [render_pkg::vram_addr_width-1:0]                 vram_addr,
  output logic                                                   byte_sel,
  output logic [render_pkg::map_data_width-1:0]                  tile_value
);

  logic [render_pkg::reg_width-1:0]        scroll_x_sel;
  logic [render_pkg::reg_width-1:0]        scroll_y_sel;
  logic [render_pkg::world_width-1:0]      world_x;
  logic [render_pkg::world_width-1:0]      world_y;
  logic [render_pkg::map_coord_width-1:0]  map_col;
  logic [render_pkg::map_coord_width-1:0]  map_row;
  logic [render_pkg::tile_bits-1:0]        tx;
  logic [render_pkg::tile_bits-1:0]        ty;
  logic [render_pkg::tile_bits-1:0]        tx_d;
  logic [render_pkg::tile_bits-1:0]        ty_d;
  logic [render_pkg::layer_width-1:0]      layer_d;
  logic                                    flip_en;
  logic                                    flip_x;
  logic                                    flip_y;
  logic                                    flip_xy;
  logic [render_pkg::tile_bits-1:0]        sx;
  logic [render_pkg::tile_bits-1:0]        sy;
  logic [render_pkg::tile_bits-1:0]        fx;
  logic [render_pkg::tile_bits-1:0]        fy;
  logic [render_pkg::reg_width-1:0]        offset_sel;
  logic [render_pkg::map_data_width+2*render_pkg::tile_bits-2:0] addr_base;

  // World position and map address in the issue cycle
  assign scroll_x_sel = scroll_x[issue_layer*render_pkg::reg_width +: render_pkg::reg_width];
  assign scroll_y_sel = scroll_y[issue_layer*render_pkg::reg_width +: render_pkg::reg_width];
  assign world_x = scroll_x_sel[render_pkg::world_width-1:0] +
                   {{(render_pkg::world_width - render_pkg::x_width){1'b0}}, issue_x};
  assign world_y = scroll_y_sel[render_pkg::world_width-1:0] + line_y;

  assign map_col  = world_x[render_pkg::world_width-1:render_pkg::tile_bits];
  assign map_row  = world_y[render_pkg::world_width-1:render_pkg::tile_bits];
  assign tx       = world_x[render_pkg::tile_bits-1:0];
  assign ty       = world_y[render_pkg::tile_bits-1:0];
  assign map_addr = {issue_layer, map_row, map_col};

  // Hold in-tile position and layer until the map entry returns
  pipe_delay #(
    .payload_t (logic [render_pkg::layer_width+2*render_pkg::tile_bits-1:0]),
    .depth     (1)
  ) pos_delay (
    .clk   (clk),
    .reset (1'b0),
    .d     ({issue_layer, ty, tx}),
    .q     ({layer_d, ty_d, tx_d})
  );

  // Map data cycle
  assign flip_en    = flip_enable[layer_d];
  assign flip_x     = flip_en & map_data[render_pkg::flip_x_bit];
  assign flip_y     = flip_en & map_data[render_pkg::flip_y_bit];
  assign flip_xy    = flip_en & map_data[render_pkg::flip_xy_bit];
  assign offset_sel = data_offset[layer_d*render_pkg::reg_width +: render_pkg::reg_width];

  // Flag bits are not part of the tile number when flipping is on
  always_comb begin
    tile_value = map_data;
    if (flip_en) begin
      tile_value[render_pkg::flip_x_bit]  = 1'b0;
      tile_value[render_pkg::flip_y_bit]  = 1'b0;
      tile_value[render_pkg::flip_xy_bit] = 1'b0;
    end
  end

  // Diagonal swap first, then the mirror flips
  assign sx = flip_xy ? ty_d : tx_d;
  assign sy = flip_xy ? tx_d : ty_d;
  assign fx = flip_x ? ~sx : sx;
  assign fy = flip_y ? ~sy : sy;

  // 256 pixels per tile and two per word
  assign addr_base = {tile_value, fy, fx[render_pkg::tile_bits-1:1]};

  always_ff @(posedge clk) begin
    vram_addr <= addr_base[render_pkg::vram_addr_width-1:0] +
                 {1'b0, offset_sel[render_pkg::reg_width-1:1]};
  end

  // Byte select rides along until vram_data is back
  pipe_delay #(
    .payload_t (logic),
    .depth     (render_pkg::fetch_latency)
  ) byte_delay (
    .clk   (clk),
    .reset (1'b0),
    .d     (fx[0]),
    .q     (byte_sel)
  );

endmodule

/* pixel_filter.sv */
// Pixel filter
// Builds the palette address and gates line buffer writes on NOP tiles and color key

module pixel_filter (
  input  logic                                                    clk,
  input  logic                                                    reset,
  input  logic                                                    issue_valid,
  input  logic [render_pkg::x_width-1:0]                          issue_x,
  input  logic [render_pkg::layer_width-1:0]                      issue_layer,
  input  logic                                                    bank,
  input  logic [render_pkg::map_data_width-1:0]                   tile_value,
  input  logic                                                    byte_sel,
  input  logic [render_pkg::vram_data_width-1:0]                  vram_data,
  input  logic [render_pkg::num_layers*render_pkg::pal_index_width-1:0] pal_index,
  input  logic [render_pkg::num_layers-1:0]                       nop_enable,
  input  logic [render_pkg::num_layers-1:0]                       transp_enable,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] nop_value,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] color_key,
  output logic [render_pkg::pal_addr_width-1:0]                   pal_addr,
  output logic                                                    buf_wr,
  output logic [render_pkg::buf_addr_width-1:0]                   buf_addr
);

  localparam int ctl_width = 1 + render_pkg::buf_addr_width + render_pkg::layer_width;

  logic                                     valid3;
  logic [render_pkg::buf_addr_width-1:0]    addr3;
  logic [render_pkg::layer_width-1:0]       layer3;
  logic [render_pkg::pixel_width-1:0]       pixel;
  logic                                     valid4;
  logic [render_pkg::layer_width-1:0]       layer4;
  logic [render_pkg::pixel_width-1:0]       pixel4;
  logic [render_pkg::map_data_width-1:0]    tile4;
  logic [render_pkg::reg_width-1:0]         nop_sel;
  logic [render_pkg::reg_width-1:0]         key_sel;
  logic                                     skip_nop;
  logic                                     skip_key;

  // Control follows the pixel to the VRAM data cycle
  pipe_delay #(
    .payload_t (logic [ctl_width-1:0]),
    .depth     (render_pkg::fetch_latency + 1)
  ) ctl_delay (
    .clk   (clk),
    .reset (reset),
    .d     ({issue_valid, bank, issue_x, issue_layer}),
    .q     ({valid3, addr3, layer3})
  );

  pipe_delay #(
    .payload_t (logic [render_pkg::map_data_width-1:0]),
    .depth     (render_pkg::render_latency - 1)
  ) tile_delay (
    .clk   (clk),
    .reset (reset),
    .d     (tile_value),
    .q     (tile4)
  );

  // Even pixel in the low byte
  assign pixel = byte_sel ? vram_data[render_pkg::pixel_width +: render_pkg::pixel_width]
                          : vram_data[0 +: render_pkg::pixel_width];
  assign pal_addr = {pal_index[layer3*render_pkg::pal_index_width +: render_pkg::pal_index_width],
                     pixel};

  // One more stage to meet the palette data
  pipe_delay #(
    .payload_t (logic [ctl_width+render_pkg::pixel_width-1:0]),
    .depth     (1)
  ) pixel_delay (
    .clk   (clk),
    .reset (reset),
    .d     ({valid3, addr3, layer3, pixel}),
    .q     ({valid4, buf_addr, layer4, pixel4})
  );

  assign nop_sel  = nop_value[layer4*render_pkg::reg_width +: render_pkg::reg_width];
  assign key_sel  = color_key[layer4*render_pkg::reg_width +: render_pkg::reg_width];
  assign skip_nop = nop_enable[layer4] && (tile4 == nop_sel);
  assign skip_key = transp_enable[layer4] && (pixel4 == key_sel[render_pkg::pixel_width-1:0]);
  assign buf_wr   = valid4 && !skip_nop && !skip_key;

endmodule

/* line_buffer.sv */
// Double line buffer
// Render side writes palette colors, scanout side reads with optional clear

module line_buffer (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                wr,
  input  logic [render_pkg::buf_addr_width-1:0] wr_addr,
  input  logic [render_pkg::color_width-1:0]    wr_data,
  input  logic [render_pkg::buf_addr_width-1:0] rd_addr,
  input  logic                                clear,
  output logic [render_pkg::color_width-1:0]    rd_data
);

  logic [render_pkg::color_width-1:0] mem [2**render_pkg::buf_addr_width];

  // Read sees the old entry in the cycle it gets cleared
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**render_pkg::buf_addr_width; i++) begin
        mem[i] <= '0;
      end
      rd_data <= '0;
    end else begin
      if (clear) begin
        mem[rd_addr] <= '0;
      end
      if (wr) begin
        mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* line_scanout.sv */
// Line scanout
// Shows each front-bank pixel twice, clears it, and packs 18-bit RGB

module line_scanout (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  scan_start,
  input  logic                                  bank,
  output logic [render_pkg::buf_addr_width-1:0] rd_addr,
  output logic                                  clear,
  input  logic [render_pkg::color_width-1:0]    rd_data,
  output logic                                  rgb_valid,
  output logic [render_pkg::rgb_width-1:0]      rgb
);

  logic                                  active;
  logic                                  front;
  logic [render_pkg::buf_addr_width-1:0] count;

  // Front bank is latched so a new render_start cannot move it mid-scan
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active    <= 1'b0;
      front     <= 1'b0;
      count     <= '0;
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= active;
      if (!active && scan_start) begin
        active <= 1'b1;
        front  <= ~bank;
        count  <= '0;
      end else if (active) begin
        count <= count + 1'b1;
        if (count == 2 * render_pkg::line_width - 1) begin
          active <= 1'b0;
        end
      end
    end
  end

  assign rd_addr = {front, count[render_pkg::x_width:1]};
  assign clear   = active & count[0];

  // Top 6 bits of blue, green and red with blue highest
  assign rgb = {rd_data[23:18], rd_data[15:10], rd_data[7:2]};

endmodule

/* tile_renderer.sv */
// Scanline tile renderer top level
// Renders two tile layers into a double line buffer and scans out the other half

module tile_renderer (
  input  logic                                                    clk,
  input  logic                                                    reset,
  input  logic                                                    render_start,
  input  logic [render_pkg::line_y_width-1:0]                     line_y,
  input  logic [render_pkg::num_layers-1:0]                       layer_enable,
  input  logic [render_pkg::num_layers-1:0]                       flip_enable,
  input  logic [render_pkg::num_layers-1:0]                       nop_enable,
  input  logic [render_pkg::num_layers-1:0]                       transp_enable,
  input  logic [render_pkg::num_layers*render_pkg::pal_index_width-1:0] pal_index,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] scroll_x,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] scroll_y,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] data_offset,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] nop_value,
  input  logic [render_pkg::num_layers*render_pkg::reg_width-1:0] color_key,
  output logic                                                    line_done,
  output logic [render_pkg::map_addr_width-1:0]                   map_addr,
  input  logic [render_pkg::map_data_width-1:0]                   map_data,
  output logic [render_pkg::vram_addr_width-1:0]                  vram_addr,
  input  logic [render_pkg::vram_data_width-1:0]                  vram_data,
  output logic [render_pkg::pal_addr_width-1:0]                   pal_addr,
  input  logic [render_pkg::color_width-1:0]                      pal_data,
  input  logic                                                    scan_start,
  output logic                                                    rgb_valid,
  output logic [render_pkg::rgb_width-1:0]                        rgb
);

  logic                                  busy;
  logic                                  accept;
  logic                                  bank;
  logic [render_pkg::line_y_width-1:0]   line_y_q;
  logic                                  issue_valid;
  logic [render_pkg::x_width-1:0]        issue_x;
  logic [render_pkg::layer_width-1:0]    issue_layer;
  logic                                  byte_sel;
  logic [render_pkg::map_data_width-1:0] tile_value;
  logic                                  buf_wr;
  logic [render_pkg::buf_addr_width-1:0] buf_addr;
  logic [render_pkg::buf_addr_width-1:0] scan_addr;
  logic                                  scan_clear;
  logic [render_pkg::color_width-1:0]    scan_data;

  // Busy until the last write has drained, so a start in that window is dropped
  assign accept = render_start & ~busy;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      bank <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
      bank <= ~bank;
    end else if (line_done) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      line_y_q <= line_y;
    end
  end

  render_control u_control (
    .clk          (clk),
    .reset        (reset),
    .render_start (accept),
    .layer_enable (layer_enable),
    .issue_valid  (issue_valid),
    .issue_x      (issue_x),
    .issue_layer  (issue_layer),
    .line_done    (line_done)
  );

  tile_fetch u_fetch (
    .clk         (clk),
    .issue_x     (issue_x),
    .issue_layer (issue_layer),
    .line_y      (line_y_q),
    .scroll_x    (scroll_x),
    .scroll_y    (scroll_y),
    .data_offset (data_offset),
    .flip_enable (flip_enable),
    .map_addr    (map_addr),
    .map_data    (map_data),
    .vram_addr   (vram_addr),
    .byte_sel    (byte_sel),
    .tile_value  (tile_value)
  );

  pixel_filter u_filter (
    .clk           (clk),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_x       (issue_x),
    .issue_layer   (issue_layer),
    .bank          (bank),
    .tile_value    (tile_value),
    .byte_sel      (byte_sel),
    .vram_data     (vram_data),
    .pal_index     (pal_index),
    .nop_enable    (nop_enable),
    .transp_enable (transp_enable),
    .nop_value     (nop_value),
    .color_key     (color_key),
    .pal_addr      (pal_addr),
    .buf_wr        (buf_wr),
    .buf_addr      (buf_addr)
  );

  line_buffer u_buffer (
    .clk     (clk),
    .reset   (reset),
    .wr      (buf_wr),
    .wr_addr (buf_addr),
    .wr_data (pal_data),
    .rd_addr (scan_addr),
    .clear   (scan_clear),
    .rd_data (scan_data)
  );

  line_scanout u_scanout (
    .clk        (clk),
    .reset      (reset),
    .scan_start (scan_start),
    .bank       (bank),
    .rd_addr    (scan_addr),
    .clear      (scan_clear),
    .rd_data    (scan_data),
    .rgb_valid  (rgb_valid),
    .rgb        (rgb)
  );

endmodule

/* tb_tile_renderer.sv */
// Testbench for the scanline tile renderer
// Models tile map, VRAM and palette, renders lines and checks scanout

module tb_tile_renderer;

  localparam int num_tests = 5;

  logic        clk;
  logic        reset;
  logic        render_start;
  logic [8:0]  line_y;
  logic [1:0]  layer_enable;
  logic [1:0]  flip_enable;
  logic [1:0]  nop_enable;
  logic [1:0]  transp_enable;
  logic [7:0]  pal_index;
  logic [31:0] scroll_x;
  logic [31:0] scroll_y;
  logic [31:0] data_offset;
  logic [31:0] nop_value;
  logic [31:0] color_key;
  logic        line_done;
  logic [10:0] map_addr;
  logic [15:0] map_data;
  logic [15:0] vram_addr;
  logic [15:0] vram_data;
  logic [11:0] pal_addr;
  logic [23:0] pal_data;
  logic        scan_start;
  logic        rgb_valid;
  logic [17:0] rgb;

  logic [15:0] map_mem [2048];
  logic [15:0] vram_mem [65536];
  logic [23:0] pal_mem [4096];
  logic [23:0] exp_colors [64];

  int scan_index;
  int errors;
  int checks;
  int failed_tests;
  int test_start_errors;

  tile_renderer UUT (
    .clk           (clk),
    .reset         (reset),
    .render_start  (render_start),
    .line_y        (line_y),
    .layer_enable  (layer_enable),
    .flip_enable   (flip_enable),
    .nop_enable    (nop_enable),
    .transp_enable (transp_enable),
    .pal_index     (pal_index),
    .scroll_x      (scroll_x),
    .scroll_y      (scroll_y),
    .data_offset   (data_offset),
    .nop_value     (nop_value),
    .color_key     (color_key),
    .line_done     (line_done),
    .map_addr      (map_addr),
    .map_data      (map_data),
    .vram_addr     (vram_addr),
    .vram_data     (vram_data),
    .pal_addr      (pal_addr),
    .pal_data      (pal_data),
    .scan_start    (scan_start),
    .rgb_valid     (rgb_valid),
    .rgb           (rgb)
  );

  always #4 clk = ~clk;

  // External memories with one cycle of read latency
  always @(posedge clk) begin
    map_data  <= map_mem[map_addr];
    vram_data <= vram_mem[vram_addr];
    pal_data  <= pal_mem[pal_addr];
  end

  // Expected 24-bit color of buffer pixel x on line y from the last layer that writes it
  function automatic logic [23:0] ref_color(input int x, input int y);
    logic [23:0] color;
    int wx, wy, tx, ty, tmp, entry, tile, vaddr, word, pixel;
    bit fx, fy, fxy;
    color = 24'h0;
    for (int l = 0; l < 2; l++) begin
      if (layer_enable[l]) begin
        wx    = (scroll_x[l*16 +: 16] + x) % 512;
        wy    = (scroll_y[l*16 +: 16] + y) % 512;
        tx    = wx % 16;
        ty    = wy % 16;
        entry = map_mem[l*1024 + (wy / 16) * 32 + wx / 16];
        tile  = entry;
        fx    = 0;
        fy    = 0;
        fxy   = 0;
        if (flip_enable[l]) begin
          fx   = entry[15];
          fy   = entry[14];
          fxy  = entry[13];
          tile = entry & 16'h1fff;
        end
        if (fxy) begin
          tmp = tx;
          tx  = ty;
          ty  = tmp;
        end
        if (fx) tx = 15 - tx;
        if (fy) ty = 15 - ty;
        // 128 words per tile and 8 words per tile row
        vaddr = (data_offset[l*16 +: 16] / 2 + tile * 128 + ty * 8 + tx / 2) % 65536;
        word  = vram_mem[vaddr];
        pixel = (tx % 2) ? (word >> 8) & 255 : word & 255;
        if (!(nop_enable[l] && tile == nop_value[l*16 +: 16]) &&
            !(transp_enable[l] && pixel == color_key[l*16 +: 8])) begin
          color = pal_mem[pal_index[l*4 +: 4] * 256 + pixel];
        end
      end
    end
    return color;
  endfunction

  // Top 6 bits of blue, green and red
  function automatic logic [17:0] to_rgb18(input logic [23:0] c);
    return {c[23:18], c[15:10], c[7:2]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  // Every valid output cycle shows buffer pixel index/2
  always @(negedge clk) begin
    if (rgb_valid) begin
      check_value($sformatf("rgb[%0d]", scan_index), rgb,
                  to_rgb18(exp_colors[scan_index / 2]));
      scan_index++;
    end
  end

  task automatic clear_registers();
    layer_enable  = 2'b00;
    flip_enable   = 2'b00;
    nop_enable    = 2'b00;
    transp_enable = 2'b00;
    pal_index     = 8'h00;
    scroll_x      = 32'h0;
    scroll_y      = 32'h0;
    data_offset   = 32'h0;
    nop_value     = 32'h0;
    color_key     = 32'h0;
  endtask

  task automatic fill_memories(input logic [15:0] vram_mask);
    for (int i = 0; i < 2048; i++) map_mem[i] = $urandom;
    for (int i = 0; i < 65536; i++) vram_mem[i] = $urandom & vram_mask;
    for (int i = 0; i < 4096; i++) pal_mem[i] = $urandom;
  endtask

  task automatic pulse_render(input int y);
    render_start = 1'b1;
    line_y       = y;
    @(negedge clk);
    render_start = 1'b0;
  endtask

  task automatic wait_line_done();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!line_done && n < 400);
    if (!line_done) begin
      $display("line_done did not pulse within 400 cycles");
      errors++;
    end
  endtask

  task automatic scan_line();
    int n;
    scan_index = 0;
    scan_start = 1'b1;
    @(negedge clk);
    scan_start = 1'b0;
    n = 1;
    while (!rgb_valid && n < 20) begin
      @(negedge clk);
      n++;
    end
    check_value("scan latency", n, 2);
    while (rgb_valid && n < 400) begin
      @(negedge clk);
      n++;
    end
    check_value("rgb_valid cycles", scan_index, 128);
  endtask

  // Render, swap banks with an empty line, then scan the rendered bank
  task automatic run_line(input int y);
    for (int x = 0; x < 64; x++) exp_colors[x] = ref_color(x, y);
    pulse_render(y);
    wait_line_done();
    @(negedge clk);
    layer_enable = 2'b00;
    pulse_render(y);
    wait_line_done();
    scan_line();
  endtask

  task automatic report_test(input int num, input string name);
    if (errors == test_start_errors) begin
      $display("Test %0d (%s): ok", num, name);
    end else begin
      $display("Test %0d (%s): %0d errors", num, name, errors - test_start_errors);
      failed_tests++;
    end
    test_start_errors = errors;
  endtask

  initial begin
    void'($urandom(84));
    clk               = 1'b0;
    reset             = 1'b1;
    render_start      = 1'b0;
    scan_start        = 1'b0;
    line_y            = 9'h0;
    map_data          = 16'h0;
    vram_data         = 16'h0;
    pal_data          = 24'h0;
    scan_index        = 0;
    errors            = 0;
    checks            = 0;
    failed_tests      = 0;
    test_start_errors = 0;
    clear_registers();
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    clear_registers();
    layer_enable = 2'b01;
    pal_index    = 8'h03;
    fill_memories(16'hffff);
    run_line($urandom_range(0, 511));
    report_test(1, "layer 0 alone");

    // Layer 1 alone with a scroll_x that crosses 512 within the line
    clear_registers();
    layer_enable = 2'b10;
    pal_index    = 8'h50;
    scroll_x     = {7'($urandom), 9'($urandom_range(449, 511)), 16'($urandom)};
    scroll_y     = $urandom;
    data_offset  = $urandom;
    fill_memories(16'hffff);
    run_line($urandom_range(0, 511));
    report_test(2, "scroll with wraparound");

    clear_registers();
    layer_enable = 2'b01;
    flip_enable  = 2'b01;
    pal_index    = 8'h0a;
    scroll_x     = $urandom;
    scroll_y     = $urandom;
    data_offset  = $urandom;
    fill_memories(16'hffff);
    run_line($urandom_range(0, 511));
    report_test(3, "tile flips");

    // Pixels take only four values so the key of 5 is hit often
    clear_registers();
    layer_enable  = 2'b11;
    nop_enable    = 2'b10;
    transp_enable = 2'b10;
    pal_index     = 8'h92;
    scroll_x      = $urandom;
    scroll_y      = $urandom;
    data_offset   = $urandom;
    nop_value     = {16'd3, 16'($urandom)};
    color_key     = {8'($urandom), 8'd5, 16'($urandom)};
    fill_memories(16'h0505);
    // Odd map columns of layer 1 hold the NOP tile
    for (int i = 1024; i < 2048; i++) begin
      map_mem[i] = (i % 2) ? 16'd3 : 16'($urandom_range(0, 7));
    end
    run_line($urandom_range(0, 511));
    report_test(4, "NOP and color key");

    clear_registers();
    fill_memories(16'hffff);
    run_line($urandom_range(0, 511));
    scan_line();
    report_test(5, "no layers and clear after read");

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             num_tests, num_tests - failed_tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Each test needs well under 600 cycles
  initial begin
    #(num_tests * 600 * 8);
    $display("Watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* sim.f */
render_pkg.sv
pipe_delay.sv
render_control.sv
tile_fetch.sv
pixel_filter.sv
line_buffer.sv
line_scanout.sv
tile_renderer.sv
tb_tile_renderer.sv

/* Bender.yml */
package:
  name: tile_renderer

sources:
  - render_pkg.sv
  - pipe_delay.sv
  - render_control.sv
  - tile_fetch.sv
  - pixel_filter.sv
  - line_buffer.sv
  - line_scanout.sv
  - tile_renderer.sv
  - target: simulation
    files:
      - tb_tile_renderer.sv
